// File: cart_addr_xlate.sv
`timescale 1ns/1ps
`default_nettype none
// ******************************
// CPU to SDRAM address mapping
// ******************************

module cart_addr_xlate (
	input  wire                   reset_n,
	input  wire                   roml,
	input  wire                   romh,
	input  wire                   umax_romh,
	input  wire                   iof,
	input  wire                   mem_write,
	input  wire                   mem_ce,
	input  wire  [15:0]           addr_in,
	input  wire cart_pkg::bank_t  bank_lo,
	input  wire cart_pkg::bank_t  bank_hi,
	input  wire                   exrom_ovr,
	input  wire                   game_ovr,
	input  wire                   iof_ena,
	input  wire                   iof_wr_ena,
	input  wire                   stb_iof,
	output cart_pkg::sdram_addr_t addr_out,
	output logic                  mem_write_out,
	output logic                  mem_ce_out,
	output logic                  io_rom
);
	logic cs_iof;

	// Bank field for addr bits 20:13
	function automatic logic [7:0] bank_field(input cart_pkg::bank_t bank, input logic ram);
		logic [7:0] field;
		if (ram)
			field = cart_pkg::ram_region | {5'd0, bank[2:0]};
		else
			field = cart_pkg::rom_region | {1'b0, bank};
		return field;
	endfunction

	assign cs_iof     = iof && (mem_write ? iof_wr_ena : iof_ena);
	assign mem_ce_out = mem_ce | (cs_iof & stb_iof);  // SDRAM cycle for $DFxx
	assign io_rom     = iof & iof_ena;

	always_comb begin
		// No RAM under ROML in Ultimax mode
		mem_write_out = mem_write & ~(roml & exrom_ovr & ~game_ovr);
		addr_out      = {9'd0, addr_in};

		if (!reset_n) begin
			if (romh && !mem_write)
				addr_out[24:13] = {4'd0, bank_field(bank_hi, 1'b0)};
			if (roml && !mem_write)
				addr_out[24:13] = {4'd0, bank_field(bank_lo, 1'b0)};
			if (cs_iof)
				addr_out[24:13] = {4'd0, bank_field('0, iof_wr_ena)};
			if (umax_romh)
				addr_out[24:12] = {4'd0, bank_field(bank_hi, 1'b0), 1'b1};  // Char ROM

			// PLA never selects both ROM halves
			assert (!(roml && romh))
				else $error("roml and romh both active");
		end
	end

endmodule

`default_nettype wire

// File: cart_bank_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
// ******************************
// Cartridge banking state
// Per type FSM on I/O writes
// ******************************

module cart_bank_ctrl (
	input  wire                   clk32,
	input  wire                   reset_n,
	input  wire  [15:0]           cart_id,
	input  wire  [7:0]            cart_exrom,
	input  wire  [7:0]            cart_game,
	input  wire                   ioe,
	input  wire                   iof,
	input  wire                   mem_write,
	input  wire  [15:0]           addr_in,
	input  wire  [7:0]            data_in,
	input  wire  [7:0]            bank_cnt,
	input  wire                   ocean_large,
	input  wire cart_pkg::bank_t  lo_entry,
	input  wire cart_pkg::bank_t  hi_entry,
	output logic [5:0]            lookup_idx,
	output cart_pkg::bank_t       bank_lo,
	output cart_pkg::bank_t       bank_hi,
	output logic                  exrom_ovr,
	output logic                  game_ovr,
	output logic                  iof_ena,
	output logic                  iof_wr_ena,
	output logic                  stb_ioe,
	output logic                  stb_iof
);
	cart_pkg::ef_write_u ef_wr;
	logic [15:0]         old_id;
	logic                old_ioe;
	logic                old_iof;
	logic                init_n;
	logic                ioe_wr;
	logic                is_ef;

	// ******************************
	// Strobes and table lookup
	// ******************************
	always_ff @(posedge clk32) begin
		if (reset_n) begin
			old_ioe <= 1'b0;
			old_iof <= 1'b0;
		end else begin
			old_ioe <= ioe;
			old_iof <= iof;
		end
	end

	assign stb_ioe = ioe & ~old_ioe;  // First cycle of IOE
	assign stb_iof = iof & ~old_iof;
	assign ioe_wr  = stb_ioe & mem_write;
	assign ef_wr   = data_in;

	assign is_ef = (cart_id == cart_pkg::ct_easyflash) || (cart_id == cart_pkg::ct_xbank);

	// Generic and power-on read entry 0
	assign lookup_idx = (is_ef && ioe_wr && !addr_in[1]) ? ef_wr.bank.idx : 6'd0;

	// ******************************
	// Banking FSM
	// ******************************
	always_ff @(posedge clk32) begin
		old_id <= cart_id;
		init_n <= 1'b1;

		if (reset_n || (old_id != cart_id)) begin
			bank_lo    <= '0;
			bank_hi    <= '0;
			exrom_ovr  <= 1'b1;  // No cartridge visible
			game_ovr   <= 1'b1;
			iof_ena    <= 1'b0;
			iof_wr_ena <= 1'b0;
			init_n     <= 1'b0;
		end else begin
			case (cart_id)
				cart_pkg::ct_generic: begin
					exrom_ovr <= cart_exrom[0];
					game_ovr  <= cart_game[0];
					bank_lo   <= lo_entry;
					bank_hi   <= hi_entry;
				end

				// Same bank mirrored at $8000 and $A000
				cart_pkg::ct_ocean: begin
					if (!init_n) begin
						exrom_ovr <= 1'b0;
						game_ovr  <= 1'b0;
					end
					if (ioe_wr) begin
						bank_lo <= {1'b0, data_in[5:0]};
						bank_hi <= {1'b0, data_in[5:0]};
					end
					if (ocean_large)
						game_ovr <= 1'b1;  // Type B uses ROML only
				end

				cart_pkg::ct_magic_desk: begin
					if (!init_n) begin
						exrom_ovr <= 1'b0;
						game_ovr  <= 1'b1;
						bank_lo   <= '0;
					end
					if (ioe_wr) begin
						// Bank bits sized to the image
						if (bank_cnt <= 8'd16)
							bank_lo <= {3'd0, data_in[3:0]};
						else if (bank_cnt <= 8'd32)
							bank_lo <= {2'd0, data_in[4:0]};
						else if (bank_cnt <= 8'd64)
							bank_lo <= {1'b0, data_in[5:0]};
						else
							bank_lo <= data_in[6:0];
						exrom_ovr <= data_in[7];  // Bit 7 hides the cartridge
					end
				end

				cart_pkg::ct_easyflash,
				cart_pkg::ct_xbank: begin
					if (!init_n) begin
						iof_ena    <= 1'b1;  // 256 bytes of RAM at $DF00
						iof_wr_ena <= 1'b1;
						exrom_ovr  <= (cart_id == cart_pkg::ct_easyflash);
						game_ovr   <= 1'b0;
						bank_lo    <= lo_entry;
						bank_hi    <= hi_entry;
					end
					if (ioe_wr) begin
						if (addr_in[1]) begin
							game_ovr  <= ~ef_wr.mode.game_n & ef_wr.mode.boot_jumper;
							exrom_ovr <= ~ef_wr.mode.exrom_n;
						end else begin
							bank_lo <= lo_entry;
							bank_hi <= hi_entry;
						end
					end
				end

				default: ;
			endcase
		end
	end

	// $DExx and $DFxx are separate I/O pages
	a_io_excl: assert property (@(posedge clk32) disable iff (reset_n)
		!(ioe && iof));

endmodule

`default_nettype wire

// File: cart_bank_table.sv
`timescale 1ns/1ps
`default_nettype none
// ******************************
// CRT bank table loader
// Maps chip packets to SDRAM banks
// ******************************

module cart_bank_table #(
	parameter int TBL_DEPTH = cart_pkg::tbl_depth
) (
	input  wire                   clk32,
	input  wire                   reset_n,
	input  wire                   cart_loading,
	input  wire                   cart_bank_wr,
	input  wire  [15:0]           cart_bank_num,
	input  wire  [15:0]           cart_bank_laddr,
	input  wire  [15:0]           cart_bank_size,
	input  wire  [24:0]           cart_bank_raddr,
	input  wire  [5:0]            lookup_idx,
	output cart_pkg::bank_t       lo_entry,
	output cart_pkg::bank_t       hi_entry,
	output logic [7:0]            bank_cnt,
	output logic                  ocean_large
);
	localparam int idx_w = $clog2(TBL_DEPTH);

	cart_pkg::bank_t  lo_bank [TBL_DEPTH];  // ROML bank per packet
	cart_pkg::bank_t  hi_bank [TBL_DEPTH];  // ROMH bank per packet
	cart_pkg::bank_t  pkt_bank;
	logic [idx_w-1:0] wr_idx;
	logic [idx_w-1:0] rd_idx;
	logic             old_loading;
	logic             load_start;
	logic             in_range;

	assign load_start = cart_loading & ~old_loading;
	assign pkt_bank   = cart_bank_raddr[19:13];
	assign in_range   = int'(cart_bank_num) < TBL_DEPTH;
	assign wr_idx     = cart_bank_num[idx_w-1:0];
	assign rd_idx     = idx_w'(lookup_idx);

	// Bank count and large image flag
	always_ff @(posedge clk32) begin
		if (reset_n) begin
			old_loading <= 1'b0;
			bank_cnt    <= 8'd0;
			ocean_large <= 1'b0;
		end else begin
			old_loading <= cart_loading;
			if (load_start) begin
				bank_cnt    <= 8'd0;
				ocean_large <= 1'b0;
			end
			if (cart_bank_wr) begin
				bank_cnt <= bank_cnt + 8'd1;
				if (int'(cart_bank_num) >= cart_pkg::ocean_large_bank)
					ocean_large <= 1'b1;
			end
		end
	end

	// 16k packets at $8000 also fill ROMH with the next 8k
	always_ff @(posedge clk32) begin
		if (cart_bank_wr && in_range) begin
			if (cart_bank_laddr <= 16'h8000) begin
				lo_bank[wr_idx] <= pkt_bank;
				if (cart_bank_size > 16'h2000)
					hi_bank[wr_idx] <= pkt_bank + 7'd1;
			end else begin
				hi_bank[wr_idx] <= pkt_bank;  // ROMH only packet
			end
		end
	end

	assign lo_entry = (int'(lookup_idx) < TBL_DEPTH) ? lo_bank[rd_idx] : '0;
	assign hi_entry = (int'(lookup_idx) < TBL_DEPTH) ? hi_bank[rd_idx] : '0;

	// One strobe per bank packet
	a_bank_wr_pulse: assert property (@(posedge clk32) disable iff (reset_n)
		cart_bank_wr |=> !cart_bank_wr);

endmodule

`default_nettype wire

// File: cart_pkg.sv
`default_nettype none
// ******************************
// Cartridge mapper shared types
// Widths, type codes, SDRAM regions
// ******************************

package cart_pkg;

	parameter int bank_w    = 7;   // 8k bank number
	parameter int tbl_depth = 64;  // Bank table entries
	parameter int addr_w    = 25;  // SDRAM word address

	typedef logic [bank_w-1:0] bank_t;
	typedef logic [addr_w-1:0] sdram_addr_t;

	// Cartridge types, as found in the CRT header
	typedef enum logic [15:0] {
		ct_generic    = 16'd0,
		ct_ocean      = 16'd5,
		ct_magic_desk = 16'd19,
		ct_easyflash  = 16'd32,
		ct_xbank      = 16'd33
	} cart_type_e;

	// Bank field prefixes for addr bits 20:13
	parameter logic [7:0] rom_region = 8'b1000_0000;  // ROM banks at 0x100000
	parameter logic [7:0] ram_region = 8'b0000_1000;  // RAM banks at 0x010000

	// Ocean type B images reach this bank number
	parameter int ocean_large_bank = 32;

	// EasyFlash $DE00 bank / $DE02 mode byte
	typedef union packed {
		struct packed {
			logic [1:0] spare;
			logic [5:0] idx;
		} bank;
		struct packed {
			logic [4:0] spare;
			logic       boot_jumper;  // 0 keeps game forced off
			logic       exrom_n;
			logic       game_n;
		} mode;
	} ef_write_u;

endpackage

`default_nettype wire

// File: cartridge.f
+incdir+.
cart_pkg.sv
cart_bank_table.sv
cart_bank_ctrl.sv
cart_addr_xlate.sv
cartridge.sv
tb_cartridge.sv

// File: cartridge.sv
`timescale 1ns/1ps
`default_nettype none
// ******************************
// C64 cartridge mapper top
// ******************************

module cartridge #(
	parameter int TBL_DEPTH = cart_pkg::tbl_depth
) (
	input  wire                   clk32,
	input  wire                   reset_n,
	input  wire                   cart_loading,
	input  wire  [15:0]           cart_id,
	input  wire  [7:0]            cart_exrom,
	input  wire  [7:0]            cart_game,
	input  wire  [15:0]           cart_bank_laddr,
	input  wire  [15:0]           cart_bank_size,
	input  wire  [15:0]           cart_bank_num,
	input  wire  [24:0]           cart_bank_raddr,
	input  wire                   cart_bank_wr,
	input  wire                   roml,
	input  wire                   romh,
	input  wire                   umax_romh,
	input  wire                   ioe,
	input  wire                   iof,
	input  wire                   mem_write,
	input  wire                   mem_ce,
	input  wire  [15:0]           addr_in,
	input  wire  [7:0]            data_in,
	output logic                  exrom,
	output logic                  game,
	output cart_pkg::sdram_addr_t addr_out,
	output logic                  mem_write_out,
	output logic                  mem_ce_out,
	output logic                  io_rom
);
	logic [5:0]      lookup_idx;
	cart_pkg::bank_t lo_entry;
	cart_pkg::bank_t hi_entry;
	cart_pkg::bank_t bank_lo;
	cart_pkg::bank_t bank_hi;
	logic [7:0]      bank_cnt;
	logic            ocean_large;
	logic            exrom_ovr;
	logic            game_ovr;
	logic            iof_ena;
	logic            iof_wr_ena;
	logic            stb_iof;

	cart_bank_table #(.TBL_DEPTH(TBL_DEPTH)) bank_table_i (
		.clk32(clk32), .reset_n(reset_n), .cart_loading(cart_loading),
		.cart_bank_wr(cart_bank_wr), .cart_bank_num(cart_bank_num),
		.cart_bank_laddr(cart_bank_laddr), .cart_bank_size(cart_bank_size),
		.cart_bank_raddr(cart_bank_raddr), .lookup_idx(lookup_idx),
		.lo_entry(lo_entry), .hi_entry(hi_entry),
		.bank_cnt(bank_cnt), .ocean_large(ocean_large)
	);

	// IOE strobe stays inside, no $DExx relocation
	cart_bank_ctrl bank_ctrl_i (
		.clk32(clk32), .reset_n(reset_n), .cart_id(cart_id),
		.cart_exrom(cart_exrom), .cart_game(cart_game), .ioe(ioe), .iof(iof),
		.mem_write(mem_write), .addr_in(addr_in), .data_in(data_in),
		.bank_cnt(bank_cnt), .ocean_large(ocean_large),
		.lo_entry(lo_entry), .hi_entry(hi_entry), .lookup_idx(lookup_idx),
		.bank_lo(bank_lo), .bank_hi(bank_hi), .exrom_ovr(exrom_ovr),
		.game_ovr(game_ovr), .iof_ena(iof_ena), .iof_wr_ena(iof_wr_ena),
		.stb_ioe(), .stb_iof(stb_iof)
	);

	cart_addr_xlate addr_xlate_i (
		.reset_n(reset_n), .roml(roml), .romh(romh), .umax_romh(umax_romh),
		.iof(iof), .mem_write(mem_write), .mem_ce(mem_ce), .addr_in(addr_in),
		.bank_lo(bank_lo), .bank_hi(bank_hi), .exrom_ovr(exrom_ovr),
		.game_ovr(game_ovr), .iof_ena(iof_ena), .iof_wr_ena(iof_wr_ena),
		.stb_iof(stb_iof), .addr_out(addr_out), .mem_write_out(mem_write_out),
		.mem_ce_out(mem_ce_out), .io_rom(io_rom)
	);

	assign exrom = exrom_ovr;  // Expansion port lines
	assign game  = game_ovr;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the cartridge mapper testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cartridge -f cartridge.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_cartridge > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The log decides the result
if grep -q "Test failures found" "$log"; then
	echo "Simulation reported failures"
	exit 1
fi

exit 0

// File: tb_cartridge_ref.svh
`ifndef TB_CARTRIDGE_REF_SVH
`define TB_CARTRIDGE_REF_SVH
// ******************************
// Cartridge mapper reference model
// ******************************

// Numerical Recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

// Magic Desk bank bits follow the image size
function automatic logic [6:0] md_bank(input int cnt, input logic [7:0] d);
	if (cnt <= 16)
		return {3'd0, d[3:0]};
	else if (cnt <= 32)
		return {2'd0, d[4:0]};
	else if (cnt <= 64)
		return {1'b0, d[5:0]};
	return d[6:0];
endfunction

// Expected {addr_out, mem_write_out, mem_ce_out, io_rom, exrom, game}
function automatic logic [29:0] expect_outputs(
	input logic        rl,
	input logic        rh,
	input logic        um,
	input logic        io_f,
	input logic        wr,
	input logic        ce,
	input logic        stb,
	input logic [15:0] a,
	input logic [6:0]  blo,
	input logic [6:0]  bhi,
	input logic        ex,
	input logic        gm,
	input logic        ie,
	input logic        iwe
);
	logic [24:0] ad;
	logic        cs;
	logic        wr_o;
	logic        ce_o;

	cs = io_f & (wr ? iwe : ie);  // $DFxx chip select
	ad = {9'd0, a};
	if (rh && !wr)
		ad = 25'h100000 | (25'(bhi) << 13) | 25'(a[12:0]);
	if (rl && !wr)
		ad = 25'h100000 | (25'(blo) << 13) | 25'(a[12:0]);
	if (cs)
		ad = (iwe ? 25'h010000 : 25'h100000) | 25'(a[12:0]);  // RAM bank 0 or ROM
	if (um)
		ad = 25'h100000 | (25'(bhi) << 13) | 25'h1000 | 25'(a[11:0]);
	wr_o = wr & ~(rl & ex & ~gm);  // Ultimax ROML is read only
	ce_o = ce | (cs & stb);
	return {ad, wr_o, ce_o, io_f & ie, ex, gm};
endfunction

`endif

// File: tb_cartridge.sv
`timescale 1ns/1ps
`default_nettype none
// ******************************
// Cartridge mapper testbench
// ******************************

module tb_cartridge;

	localparam int n_tests = 6;

	logic        clk32;
	logic        reset_n;
	logic        cart_loading;
	logic [15:0] cart_id;
	logic [7:0]  cart_exrom;
	logic [7:0]  cart_game;
	logic [15:0] cart_bank_laddr;
	logic [15:0] cart_bank_size;
	logic [15:0] cart_bank_num;
	logic [24:0] cart_bank_raddr;
	logic        cart_bank_wr;
	logic        roml;
	logic        romh;
	logic        umax_romh;
	logic        ioe;
	logic        iof;
	logic        mem_write;
	logic        mem_ce;
	logic [15:0] addr_in;
	logic [7:0]  data_in;
	logic        exrom;
	logic        game;
	logic [24:0] addr_out;
	logic        mem_write_out;
	logic        mem_ce_out;
	logic        io_rom;

	// Model of the bank table and banking state
	logic [6:0]  m_lo [64];
	logic [6:0]  m_hi [64];
	logic [6:0]  m_bank_lo;
	logic [6:0]  m_bank_hi;
	logic        m_exrom;
	logic        m_game;
	logic        m_iof_ena;
	logic        m_iof_wr_ena;
	int          m_bank_cnt;
	logic        m_ocean_large;

	logic [31:0] rng;
	int          cyc = 0;
	int          errors = 0;
	int          checks = 0;
	int          test_num = 0;
	int          test_checks;
	int          test_errors;
	int          due_q[$];    // Cycle in which each check is due
	logic [29:0] exp_q[$];

	`include "tb_cartridge_ref.svh"

	cartridge cartridge_i (.*);

	initial begin
		clk32 = 1'b0;
		forever #50 clk32 = ~clk32;
	end

	always @(posedge clk32) cyc <= cyc + 1;

	function automatic logic [15:0] next_rand();
		rng = lcg_next(rng);
		return rng[31:16];  // High half has the long period
	endfunction

	task automatic show_mismatch(input string name, input logic [24:0] want,
		input logic [24:0] got);
		errors++;
		$display("FAILED at %0d ns: %s expected %h got %h", $time, name, want, got);
	endtask

	task automatic compare_outputs(input logic [29:0] exp);
		checks++;
		assert (addr_out === exp[29:5]) else show_mismatch("addr_out", exp[29:5], addr_out);
		assert (mem_write_out === exp[4])
			else show_mismatch("mem_write_out", 25'(exp[4]), 25'(mem_write_out));
		assert (mem_ce_out === exp[3])
			else show_mismatch("mem_ce_out", 25'(exp[3]), 25'(mem_ce_out));
		assert (io_rom === exp[2]) else show_mismatch("io_rom", 25'(exp[2]), 25'(io_rom));
		assert (exrom === exp[1]) else show_mismatch("exrom", 25'(exp[1]), 25'(exrom));
		assert (game === exp[0]) else show_mismatch("game", 25'(exp[0]), 25'(game));
	endtask

	// ******************************
	// Compare process
	// ******************************
	initial begin
		logic [29:0] exp;
		forever begin
			@(negedge clk32);
			#40;  // Late in the low phase, inputs settled
			while (due_q.size() > 0 && due_q[0] <= cyc) begin
				void'(due_q.pop_front());
				exp = exp_q.pop_front();
				compare_outputs(exp);
			end
		end
	end

	initial begin
		repeat (n_tests * 400) @(posedge clk32);
		$display("Timeout: the tests did not finish within %0d cycles", n_tests * 400);
		$display("Test failures found");
		$finish;
	end

	// ******************************
	// Stimulus tasks
	// ******************************
	task automatic cpu_access(input logic rl, input logic rh, input logic um,
		input logic io_f, input logic wr, input logic ce, input logic [15:0] a);
		@(negedge clk32);
		roml      = rl;
		romh      = rh;
		umax_romh = um;
		iof       = io_f;
		mem_write = wr;
		mem_ce    = ce;
		addr_in   = a;
		due_q.push_back(cyc);  // Strobe cycle
		exp_q.push_back(expect_outputs(rl, rh, um, io_f, wr, ce, io_f, a, m_bank_lo,
			m_bank_hi, m_exrom, m_game, m_iof_ena, m_iof_wr_ena));
		due_q.push_back(cyc + 2);
		exp_q.push_back(expect_outputs(rl, rh, um, io_f, wr, ce, 1'b0, a, m_bank_lo,
			m_bank_hi, m_exrom, m_game, m_iof_ena, m_iof_wr_ena));
		repeat (3) @(negedge clk32);
		roml      = 1'b0;
		romh      = 1'b0;
		umax_romh = 1'b0;
		iof       = 1'b0;
		mem_write = 1'b0;
		mem_ce    = 1'b0;
	endtask

	task automatic read_roml();
		cpu_access(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 16'h8000 | (next_rand() & 16'h1fff));
	endtask

	task automatic read_romh();
		cpu_access(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 16'ha000 | (next_rand() & 16'h1fff));
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		@(negedge clk32);
		ioe       = 1'b1;
		mem_write = 1'b1;
		addr_in   = a;
		data_in   = d;
		@(negedge clk32);
		ioe       = 1'b0;
		mem_write = 1'b0;
	endtask

	task automatic ef_mode(input logic [7:0] d);
		io_write(16'hde02, d);
		m_game  = ~d[0] & d[2];  // Boot jumper gates game
		m_exrom = ~d[1];
	endtask

	task automatic start_load();
		@(negedge clk32);
		cart_loading = 1'b1;
		@(negedge clk32);
		m_bank_cnt    = 0;
		m_ocean_large = 1'b0;
	endtask

	task automatic end_load();
		@(negedge clk32);
		cart_loading = 1'b0;
	endtask

	task automatic load_bank(input int num, input logic [15:0] laddr,
		input logic [15:0] size, input logic [24:0] raddr);
		logic [6:0] b;
		b = raddr[19:13];
		@(negedge clk32);
		cart_bank_num   = 16'(num);
		cart_bank_laddr = laddr;
		cart_bank_size  = size;
		cart_bank_raddr = raddr;
		cart_bank_wr    = 1'b1;
		@(negedge clk32);
		cart_bank_wr = 1'b0;
		if (num < 64) begin
			if (laddr <= 16'h8000) begin
				m_lo[num] = b;
				if (size > 16'h2000)
					m_hi[num] = b + 7'd1;  // 16k packet
			end else begin
				m_hi[num] = b;
			end
		end
		m_bank_cnt++;
		if (num >= 32)
			m_ocean_large = 1'b1;
	endtask

	task automatic begin_test();
		test_num++;
		test_checks = checks;
		test_errors = errors;
	endtask

	task automatic end_test(input string name);
		while (due_q.size() != 0)
			@(negedge clk32);
		$display("test %0d %s: %0d checks, %0d errors", test_num, name,
			checks - test_checks, errors - test_errors);
	endtask

	// ******************************
	// Test sequence
	// ******************************
	initial begin
		logic [15:0] r;
		logic [7:0]  d;
		logic [5:0]  idx;
		int          i;
		int          pass;

		reset_n         = 1'b1;
		cart_loading    = 1'b0;
		cart_id         = 16'd0;
		cart_exrom      = 8'd0;
		cart_game       = 8'd0;
		cart_bank_laddr = 16'd0;
		cart_bank_size  = 16'd0;
		cart_bank_num   = 16'd0;
		cart_bank_raddr = 25'd0;
		cart_bank_wr    = 1'b0;
		roml            = 1'b0;
		romh            = 1'b0;
		umax_romh       = 1'b0;
		ioe             = 1'b0;
		iof             = 1'b0;
		mem_write       = 1'b0;
		mem_ce          = 1'b0;
		addr_in         = 16'd0;
		data_in         = 8'd0;
		rng             = 32'heaa2_027f;
		m_iof_ena       = 1'b0;
		m_iof_wr_ena    = 1'b0;
		repeat (16) @(posedge clk32);
		@(negedge clk32);
		reset_n = 1'b0;
		repeat (2) @(negedge clk32);

		begin_test();
		cart_exrom = 8'(next_rand());
		cart_game  = 8'(next_rand());
		r          = next_rand();
		start_load();
		load_bank(0, 16'h8000, 16'h4000, {r[11:0], 13'd0});
		end_load();
		m_bank_lo = m_lo[0];
		m_bank_hi = m_hi[0];
		m_exrom   = cart_exrom[0];
		m_game    = cart_game[0];
		repeat (4) begin
			read_roml();
			read_romh();
		end
		cpu_access(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 16'he000 | (next_rand() & 16'h1fff));
		end_test("generic");

		begin_test();
		cart_id = 16'd5;
		repeat (4) @(negedge clk32);
		m_exrom   = 1'b0;
		m_game    = 1'b0;
		m_bank_lo = 7'd0;
		m_bank_hi = 7'd0;
		repeat (6) begin
			d = 8'(next_rand());
			io_write(16'hde00, d);
			m_bank_lo = {1'b0, d[5:0]};  // One bank for both halves
			m_bank_hi = m_bank_lo;
			read_roml();
			read_romh();
		end
		start_load();
		for (i = 0; i <= 32; i++)
			load_bank(i, 16'h8000, 16'h2000, 25'(i) << 13);
		end_load();
		if (m_ocean_large)
			m_game = 1'b1;
		read_roml();
		end_test("ocean");

		begin_test();
		cart_id = 16'd19;
		repeat (4) @(negedge clk32);
		m_exrom   = 1'b0;
		m_game    = 1'b1;
		m_bank_lo = 7'd0;
		m_bank_hi = 7'd0;
		for (pass = 0; pass < 2; pass++) begin
			start_load();
			for (i = 0; i < (pass == 0 ? 16 : 64); i++)
				load_bank(i, 16'h8000, 16'h2000, 25'(i + 64) << 13);
			end_load();
			repeat (5) begin
				d = 8'(next_rand());
				io_write(16'hde00, d);
				m_bank_lo = md_bank(m_bank_cnt, d);
				m_exrom   = d[7];
				read_roml();
			end
		end
		end_test("magic desk");

		begin_test();
		cart_id = 16'd32;
		repeat (4) @(negedge clk32);
		m_exrom      = 1'b1;
		m_game       = 1'b0;
		m_iof_ena    = 1'b1;
		m_iof_wr_ena = 1'b1;
		m_bank_lo    = m_lo[0];
		m_bank_hi    = m_hi[0];
		start_load();
		for (i = 0; i < 16; i++) begin
			r = next_rand();
			load_bank(i, 16'h8000, 16'h4000, {r[11:0], 13'd0});
		end
		for (i = 16; i < 24; i++) begin  // Separate ROML and ROMH chips
			r = next_rand();
			load_bank(i, 16'h8000, 16'h2000, {r[11:0], 13'd0});
			r = next_rand();
			load_bank(i, 16'ha000, 16'h2000, {r[11:0], 13'd0});
		end
		end_load();
		repeat (6) begin
			r   = next_rand();
			idx = 6'(r % 16'd24);
			io_write(16'hde00, {r[15:14], idx});
			m_bank_lo = m_lo[idx];
			m_bank_hi = m_hi[idx];
			read_roml();
			read_romh();
		end
		repeat (4) begin
			ef_mode(8'(next_rand()));
			read_roml();
		end
		end_test("easyflash banking");

		begin_test();
		repeat (4) begin
			cpu_access(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 16'hdf00 | (next_rand() & 16'h00ff));
			cpu_access(1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 16'hdf00 | (next_rand() & 16'h00ff));
		end
		end_test("easyflash iof ram");

		begin_test();
		ef_mode(8'h05);  // Ultimax
		cpu_access(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 16'h8000 | (next_rand() & 16'h1fff));
		cpu_access(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 16'ha000 | (next_rand() & 16'h1fff));
		ef_mode(8'h04);
		cpu_access(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 16'h8000 | (next_rand() & 16'h1fff));
		end_test("ultimax protection");

		$display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire
